//--- common/csr_cmd_if.sv
`timescale 1ns/1ns

interface csr_cmd_if;

   // read port, combinational from raddr
   logic [csr_pkg::csr_num_w-1:0] raddr;
   logic [csr_pkg::grlen-1:0]     rdata;

   // masked write, lands on the next clk edge
   logic [csr_pkg::csr_num_w-1:0] waddr;
   logic [csr_pkg::grlen-1:0]     wdata;
   logic [csr_pkg::grlen-1:0]     mask;
   logic                          wen;

   modport decoder (
      output raddr,
      output waddr,
      output wdata,
      output mask,
      output wen,
      input  rdata
   );

   modport regfile (
      input  raddr,
      input  waddr,
      input  wdata,
      input  mask,
      input  wen,
      output rdata
   );

endinterface

//--- common/csr_pkg.sv
package csr_pkg;

   // datapath widths
   localparam int grlen     = 32;
   localparam int csr_num_w = 14;
   localparam int plv_w     = 2;

   // implemented csr numbers
   localparam logic [csr_num_w-1:0] csr_crmd   = 14'h000;
   localparam logic [csr_num_w-1:0] csr_prmd   = 14'h001;
   localparam logic [csr_num_w-1:0] csr_era    = 14'h006;
   localparam logic [csr_num_w-1:0] csr_eentry = 14'h00c;
   // local boot security register
   localparam logic [csr_num_w-1:0] csr_bsec   = 14'h100;

   // crmd fields
   localparam int crmd_plv_lo = 0;
   localparam int crmd_ie_bit = 2;

   // prmd holds the crmd fields saved on exception entry
   localparam int prmd_pplv_lo = 0;
   localparam int prmd_pie_bit = 2;

   // bsec eeprom flush, sticky until reset
   localparam int bsec_ef_bit = 0;

   // execute-stage csr opcodes
   typedef enum logic [2:0] {
      op_nop,
      op_csrrd,
      op_csrwr,
      op_csrxchg,
      op_ertn
   } csr_op_e;

   // reported with each redirect
   typedef enum logic [1:0] {
      cause_none,
      cause_ale,
      cause_illinst,
      cause_ertn
   } trap_cause_e;

endpackage

//--- csr/csr_regfile.sv
`timescale 1ns/1ns

module csr_regfile (
   input  logic                      clk,
   input  logic                      reset,
   csr_cmd_if.regfile                cmd,
   input  logic                      exception,
   input  logic                      ertn,
   input  logic [csr_pkg::grlen-1:0] pc,
   output logic [csr_pkg::grlen-1:0] eentry,
   output logic [csr_pkg::grlen-1:0] era,
   output logic                      bsec_ef
);

   // implemented fields
   logic                      crmd_ie;
   logic [csr_pkg::plv_w-1:0] crmd_plv;
   logic                      prmd_pie;
   logic [csr_pkg::plv_w-1:0] prmd_pplv;

   // full-width views, unimplemented bits are zero
   logic [csr_pkg::grlen-1:0] crmd;
   logic [csr_pkg::grlen-1:0] prmd;
   logic [csr_pkg::grlen-1:0] bsec;

   logic crmd_wen;
   logic prmd_wen;
   logic era_wen;
   logic eentry_wen;
   logic bsec_wen;

   logic [csr_pkg::grlen-1:0] crmd_merged;
   logic [csr_pkg::grlen-1:0] prmd_merged;
   logic [csr_pkg::grlen-1:0] era_merged;
   logic [csr_pkg::grlen-1:0] eentry_merged;

   // keep old bits where mask is clear
   function automatic logic [csr_pkg::grlen-1:0] masked_merge(
      input logic [csr_pkg::grlen-1:0] old_value,
      input logic [csr_pkg::grlen-1:0] new_value,
      input logic [csr_pkg::grlen-1:0] mask
   );
      return (old_value & ~mask) | (new_value & mask);
   endfunction

   always_comb begin
      crmd = '0;
      crmd[csr_pkg::crmd_plv_lo +: csr_pkg::plv_w] = crmd_plv;
      crmd[csr_pkg::crmd_ie_bit] = crmd_ie;
      prmd = '0;
      prmd[csr_pkg::prmd_pplv_lo +: csr_pkg::plv_w] = prmd_pplv;
      prmd[csr_pkg::prmd_pie_bit] = prmd_pie;
      bsec = '0;
      bsec[csr_pkg::bsec_ef_bit] = bsec_ef;
   end

   // write select per register
   assign crmd_wen   = cmd.wen && (cmd.waddr == csr_pkg::csr_crmd);
   assign prmd_wen   = cmd.wen && (cmd.waddr == csr_pkg::csr_prmd);
   assign era_wen    = cmd.wen && (cmd.waddr == csr_pkg::csr_era);
   assign eentry_wen = cmd.wen && (cmd.waddr == csr_pkg::csr_eentry);
   assign bsec_wen   = cmd.wen && (cmd.waddr == csr_pkg::csr_bsec);

   assign crmd_merged   = masked_merge(crmd, cmd.wdata, cmd.mask);
   assign prmd_merged   = masked_merge(prmd, cmd.wdata, cmd.mask);
   assign era_merged    = masked_merge(era, cmd.wdata, cmd.mask);
   assign eentry_merged = masked_merge(eentry, cmd.wdata, cmd.mask);

   // crmd: exception clears, ertn restores from prmd
   always_ff @(posedge clk) begin
      if (reset) begin
         crmd_ie  <= 1'b0;
         crmd_plv <= '0;
      end else if (exception) begin
         crmd_ie  <= 1'b0;
         crmd_plv <= '0;
      end else if (ertn) begin
         crmd_ie  <= prmd_pie;
         crmd_plv <= prmd_pplv;
      end else if (crmd_wen) begin
         crmd_ie  <= crmd_merged[csr_pkg::crmd_ie_bit];
         crmd_plv <= crmd_merged[csr_pkg::crmd_plv_lo +: csr_pkg::plv_w];
      end
   end

   // prmd saves the crmd fields on exception entry
   always_ff @(posedge clk) begin
      if (reset) begin
         prmd_pie  <= 1'b0;
         prmd_pplv <= '0;
      end else if (exception) begin
         prmd_pie  <= crmd_ie;
         prmd_pplv <= crmd_plv;
      end else if (prmd_wen) begin
         prmd_pie  <= prmd_merged[csr_pkg::prmd_pie_bit];
         prmd_pplv <= prmd_merged[csr_pkg::prmd_pplv_lo +: csr_pkg::plv_w];
      end
   end

   // era takes the faulting pc
   always_ff @(posedge clk) begin
      if (reset) begin
         era <= '0;
      end else if (exception) begin
         era <= pc;
      end else if (era_wen) begin
         era <= era_merged;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         eentry <= '0;
      end else if (eentry_wen) begin
         eentry <= eentry_merged;
      end
   end

   // sticky, a written 0 never clears it
   always_ff @(posedge clk) begin
      if (reset) begin
         bsec_ef <= 1'b0;
      end else if (bsec_wen && cmd.mask[csr_pkg::bsec_ef_bit] &&
                   cmd.wdata[csr_pkg::bsec_ef_bit]) begin
         bsec_ef <= 1'b1;
      end
   end

   // and-or read mux by number
   assign cmd.rdata = ({csr_pkg::grlen{cmd.raddr == csr_pkg::csr_crmd}}   & crmd)   |
                      ({csr_pkg::grlen{cmd.raddr == csr_pkg::csr_prmd}}   & prmd)   |
                      ({csr_pkg::grlen{cmd.raddr == csr_pkg::csr_era}}    & era)    |
                      ({csr_pkg::grlen{cmd.raddr == csr_pkg::csr_eentry}} & eentry) |
                      ({csr_pkg::grlen{cmd.raddr == csr_pkg::csr_bsec}}   & bsec);

   // trap controller ranks these, never both
   a_exc_ertn_excl : assert property (
      @(posedge clk) disable iff (reset)
      !(exception && ertn)
   ) else $error("csr_regfile: exception and ertn in the same cycle");

   // write kill from the trap side reaches the decoder
   a_no_write_on_trap : assert property (
      @(posedge clk) disable iff (reset)
      (exception || ertn) |-> !cmd.wen
   ) else $error("csr_regfile: csr write during trap event");

endmodule

//--- dv/tb_csr_unit.sv
`timescale 1ns/1ns

module tb_csr_unit;

   localparam int random_ops  = 2000;
   localparam int cycle_limit = 2 * random_ops + 16;

   logic                          clk, reset, op_valid;
   csr_pkg::csr_op_e              op;
   logic [csr_pkg::csr_num_w-1:0] csr_num;
   logic [31:0]                   rd_value, rj_value, pc;
   logic                          ale, illinst;
   logic                          rdata_valid, redirect_valid, bsec_ef;
   logic [31:0]                   rdata_out, redirect_pc;
   csr_pkg::trap_cause_e          redirect_cause;

   // reference model registers, unimplemented bits kept at zero
   logic [31:0]          m_crmd, m_prmd, m_era, m_eentry;
   logic                 m_bsec;
   // expected outputs of the op in flight
   logic                 exp_rvalid, exp_redir, exp_bsec;
   logic [31:0]          exp_rdata, exp_rpc;
   csr_pkg::trap_cause_e exp_cause;
   logic [31:0]          lcg_state;
   int                   cycle_count = 0;

   logic [csr_pkg::csr_num_w-1:0] csr_list [5] = '{csr_pkg::csr_crmd, csr_pkg::csr_prmd,
      csr_pkg::csr_era, csr_pkg::csr_eentry, csr_pkg::csr_bsec};

   csr_unit i_csr_unit (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
         $display("timeout: stimulus still running after %0d cycles", cycle_limit);
         $display("TEST FAIL");
         $fatal(1, "timeout");
      end
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic [31:0] model_read(input logic [13:0] num);
      case (num)
         csr_pkg::csr_crmd:   return m_crmd;
         csr_pkg::csr_prmd:   return m_prmd;
         csr_pkg::csr_era:    return m_era;
         csr_pkg::csr_eentry: return m_eentry;
         csr_pkg::csr_bsec:   return {31'b0, m_bsec};
         default:             return 32'b0;
      endcase
   endfunction

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         $display("Fail at %0t: %s is %h, expected %h", $time, name, actual, expected);
         $display("TEST FAIL");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   task automatic drive_inputs(input logic valid, input csr_pkg::csr_op_e o,
                               input logic [13:0] num, input logic [31:0] rd, rj,
                               input logic a, il, input logic [31:0] p);
      op_valid <= valid;
      op       <= o;
      csr_num  <= num;
      rd_value <= rd;
      rj_value <= rj;
      ale      <= a;
      illinst  <= il;
      pc       <= p;
   endtask

   // one stimulus cycle, the previous op's results are checked at the negedge
   task automatic do_op(input logic valid, input csr_pkg::csr_op_e o,
                        input logic [13:0] num, input logic [31:0] rd, rj,
                        input logic a, il, input logic [31:0] p);
      logic        access, known, exc, ret;
      logic [31:0] mask;
      @(posedge clk);
      drive_inputs(valid, o, num, rd, rj, a, il, p);
      @(negedge clk);
      check_value("rdata_valid", {31'b0, rdata_valid}, {31'b0, exp_rvalid});
      if (exp_rvalid) begin
         check_value("rdata_out", rdata_out, exp_rdata);
      end
      check_value("redirect_valid", {31'b0, redirect_valid}, {31'b0, exp_redir});
      if (exp_redir) begin
         check_value("redirect_pc", redirect_pc, exp_rpc);
      end
      check_value("redirect_cause", {30'b0, redirect_cause}, {30'b0, exp_cause});
      check_value("bsec_ef", {31'b0, bsec_ef}, {31'b0, exp_bsec});
      access = valid && (o inside {csr_pkg::op_csrrd, csr_pkg::op_csrwr, csr_pkg::op_csrxchg});
      known  = num inside {csr_pkg::csr_crmd, csr_pkg::csr_prmd, csr_pkg::csr_era,
                           csr_pkg::csr_eentry, csr_pkg::csr_bsec};
      exc    = valid && (a || il || (access && !known));
      ret    = valid && (o == csr_pkg::op_ertn) && !exc;
      mask   = (o == csr_pkg::op_csrxchg) ? rj : 32'hffff_ffff;
      exp_rvalid = access;
      exp_rdata  = model_read(num);
      exp_redir  = exc || ret;
      exp_rpc    = exc ? m_eentry : m_era;
      exp_cause  = (valid && a) ? csr_pkg::cause_ale :
                   exc ? csr_pkg::cause_illinst :
                   ret ? csr_pkg::cause_ertn : csr_pkg::cause_none;
      // only ie and plv, pie and pplv exist in bits 2:0
      if (exc) begin
         m_prmd = m_crmd;
         m_crmd = 32'b0;
         m_era  = p;
      end else if (ret) begin
         m_crmd = m_prmd;
      end else if (valid && (o == csr_pkg::op_csrwr || o == csr_pkg::op_csrxchg)) begin
         case (num)
            csr_pkg::csr_crmd:   m_crmd   = ((m_crmd & ~mask) | (rd & mask)) & 32'h7;
            csr_pkg::csr_prmd:   m_prmd   = ((m_prmd & ~mask) | (rd & mask)) & 32'h7;
            csr_pkg::csr_era:    m_era    = (m_era & ~mask) | (rd & mask);
            csr_pkg::csr_eentry: m_eentry = (m_eentry & ~mask) | (rd & mask);
            csr_pkg::csr_bsec:   m_bsec   = m_bsec | (mask[0] & rd[0]);
            default:             ;
         endcase
      end
      exp_bsec = m_bsec;
   endtask

   task automatic apply_reset();
      reset <= 1'b1;
      drive_inputs(1'b0, csr_pkg::op_nop, '0, '0, '0, 1'b0, 1'b0, '0);
      repeat (16) @(posedge clk);
      reset <= 1'b0;
      m_crmd     = 32'b0;
      m_prmd     = 32'b0;
      m_era      = 32'b0;
      m_eentry   = 32'b0;
      m_bsec     = 1'b0;
      exp_rvalid = 1'b0;
      exp_redir  = 1'b0;
      exp_bsec   = 1'b0;
      exp_cause  = csr_pkg::cause_none;
   endtask

   task automatic read_all();
      foreach (csr_list[i]) begin
         do_op(1'b1, csr_pkg::op_csrrd, csr_list[i], '0, '0, 1'b0, 1'b0, '0);
      end
   endtask

   task automatic random_op();
      logic [31:0]      r;
      logic [31:0]      sel;
      logic [13:0]      num;
      csr_pkg::csr_op_e o;
      r   = lcg_next();
      sel = lcg_next();
      case (r[31:28])
         4'd0, 4'd1:             o = csr_pkg::op_nop;
         4'd2, 4'd3, 4'd4, 4'd5: o = csr_pkg::op_csrrd;
         4'd6, 4'd7, 4'd8, 4'd9: o = csr_pkg::op_csrwr;
         4'd14, 4'd15:           o = csr_pkg::op_ertn;
         default:                o = csr_pkg::op_csrxchg;
      endcase
      // mostly implemented numbers, one in eight anywhere
      num = (sel[31:29] == 3'd7) ? sel[27:14] : csr_list[sel[28:26] % 3'd5];
      do_op(r[27:25] != 3'd0, o, num, lcg_next(),
            (r[14:13] == 2'd0) ? 32'hffff_ffff : lcg_next(),
            r[24:20] == 5'd0, r[19:15] == 5'd0, lcg_next() & 32'hffff_fffc);
   endtask

   initial begin
      lcg_state = 32'd85069;
      apply_reset();
      read_all();
      do_op(1'b1, csr_pkg::op_csrwr, csr_pkg::csr_crmd, 32'hffff_ffff, '0,
            1'b0, 1'b0, '0);
      do_op(1'b1, csr_pkg::op_csrxchg, csr_pkg::csr_prmd, 32'h0000_0005, 32'h0000_000e,
            1'b0, 1'b0, '0);
      do_op(1'b1, csr_pkg::op_csrxchg, csr_pkg::csr_eentry, 32'h1234_5678, 32'h0000_ff00,
            1'b0, 1'b0, '0);
      read_all();
      // ale on a write, the write is dropped
      do_op(1'b1, csr_pkg::op_csrwr, csr_pkg::csr_eentry, 32'h5555_aaaa, '0,
            1'b1, 1'b0, 32'h0000_1000);
      do_op(1'b1, csr_pkg::op_ertn, '0, '0, '0, 1'b0, 1'b0, '0);
      // exception beats ertn
      do_op(1'b1, csr_pkg::op_ertn, '0, '0, '0, 1'b0, 1'b1, 32'h0000_2000);
      do_op(1'b1, csr_pkg::op_csrrd, 14'h0abc, '0, '0, 1'b0, 1'b0, 32'h0000_3000);
      // sticky eeprom flush
      do_op(1'b1, csr_pkg::op_csrxchg, csr_pkg::csr_bsec, 32'h1, 32'h1, 1'b0, 1'b0, '0);
      do_op(1'b1, csr_pkg::op_csrwr, csr_pkg::csr_bsec, 32'h0, '0, 1'b0, 1'b0, '0);
      read_all();
      for (int i = 0; i < random_ops; i++) begin
         random_op();
      end
      do_op(1'b0, csr_pkg::op_nop, '0, '0, '0, 1'b0, 1'b0, '0);
      @(posedge clk);
      apply_reset();
      read_all();
      do_op(1'b0, csr_pkg::op_nop, '0, '0, '0, 1'b0, 1'b0, '0);
      $display("TEST PASS");
      $finish;
   end

endmodule

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sim.f --top-module tb_csr_unit -o tb_csr_unit \
   || { echo "build failed"; exit 1; }
result=$(./obj_dir/tb_csr_unit 2>&1)
echo "$result"
echo "$result" | grep -q "^TEST PASS$" && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

//--- sim.f
common/csr_pkg.sv
common/csr_cmd_if.sv
source/csr_decode.sv
csr/csr_regfile.sv
source/csr_trap_ctl.sv
source/csr_unit.sv
dv/tb_csr_unit.sv

//--- source/csr_decode.sv
`timescale 1ns/1ns

module csr_decode (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          op_valid,
   input  csr_pkg::csr_op_e              op,
   input  logic [csr_pkg::csr_num_w-1:0] csr_num,
   input  logic [csr_pkg::grlen-1:0]     rd_value,
   input  logic [csr_pkg::grlen-1:0]     rj_value,
   input  logic                          write_kill,
   output logic                          illinst_csr,
   csr_cmd_if.decoder                    cmd,
   output logic                          rdata_valid,
   output logic [csr_pkg::grlen-1:0]     rdata_out
);

   logic csr_access;
   logic csr_write;
   logic csr_known;

   // any op that touches a csr
   assign csr_access = op_valid &&
                       ((op == csr_pkg::op_csrrd) ||
                        (op == csr_pkg::op_csrwr) ||
                        (op == csr_pkg::op_csrxchg));

   // csrrd only reads
   assign csr_write = op_valid &&
                      ((op == csr_pkg::op_csrwr) ||
                       (op == csr_pkg::op_csrxchg));

   // the five implemented numbers
   assign csr_known = csr_num inside {
      csr_pkg::csr_crmd,
      csr_pkg::csr_prmd,
      csr_pkg::csr_era,
      csr_pkg::csr_eentry,
      csr_pkg::csr_bsec
   };

   assign illinst_csr = csr_access && !csr_known;

   // same number for both sides of an exchange
   assign cmd.raddr = csr_num;
   assign cmd.waddr = csr_num;
   assign cmd.wdata = rd_value;

   // csrwr writes every bit, csrxchg only where rj is set
   assign cmd.mask = (op == csr_pkg::op_csrxchg) ? rj_value : '1;

   // trapping or returning instructions must not commit a write
   assign cmd.wen = csr_write && !write_kill;

   always_ff @(posedge clk) begin
      if (reset) begin
         rdata_valid <= 1'b0;
      end else begin
         rdata_valid <= csr_access;
      end
   end

   // old value, sampled before the write edge
   always_ff @(posedge clk) begin
      if (csr_access) begin
         rdata_out <= cmd.rdata;
      end
   end

   // an unimplemented number always comes back as a write kill
   a_illinst_kills_write : assert property (
      @(posedge clk) disable iff (reset)
      illinst_csr |-> write_kill
   ) else $error("csr_decode: unimplemented csr access without write_kill");

endmodule

//--- source/csr_trap_ctl.sv
`timescale 1ns/1ns

module csr_trap_ctl (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        op_valid,
   input  csr_pkg::csr_op_e            op,
   input  logic                        ale,
   input  logic                        illinst,
   input  logic                        illinst_csr,
   input  logic [csr_pkg::grlen-1:0]   eentry,
   input  logic [csr_pkg::grlen-1:0]   era,
   output logic                        exception,
   output logic                        ertn,
   output logic                        write_kill,
   output logic                        redirect_valid,
   output logic [csr_pkg::grlen-1:0]   redirect_pc,
   output csr_pkg::trap_cause_e        redirect_cause
);

   logic                 ale_hit;
   logic                 ill_hit;
   logic                 ertn_hit;
   logic                 trap_event;
   csr_pkg::trap_cause_e cause;

   // flags only count with a live instruction
   assign ale_hit  = op_valid && ale;
   assign ill_hit  = op_valid && (illinst || illinst_csr);
   assign ertn_hit = op_valid && (op == csr_pkg::op_ertn);

   // any exception outranks ertn
   assign exception  = ale_hit || ill_hit;
   assign ertn       = ertn_hit && !exception;
   assign write_kill = exception || ertn_hit;
   assign trap_event = exception || ertn;

   // ale, then illinst, then ertn
   always_comb begin
      if (ale_hit) begin
         cause = csr_pkg::cause_ale;
      end else if (ill_hit) begin
         cause = csr_pkg::cause_illinst;
      end else if (ertn_hit) begin
         cause = csr_pkg::cause_ertn;
      end else begin
         cause = csr_pkg::cause_none;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         redirect_valid <= 1'b0;
         redirect_cause <= csr_pkg::cause_none;
      end else begin
         redirect_valid <= trap_event;
         redirect_cause <= cause;
      end
   end

   // target as seen in the event cycle, before the era update lands
   always_ff @(posedge clk) begin
      if (trap_event) begin
         redirect_pc <= exception ? eentry : era;
      end
   end

endmodule

//--- source/csr_unit.sv
`timescale 1ns/1ns

module csr_unit (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          op_valid,
   input  csr_pkg::csr_op_e              op,
   input  logic [csr_pkg::csr_num_w-1:0] csr_num,
   input  logic [csr_pkg::grlen-1:0]     rd_value,
   input  logic [csr_pkg::grlen-1:0]     rj_value,
   input  logic                          ale,
   input  logic                          illinst,
   input  logic [csr_pkg::grlen-1:0]     pc,
   output logic                          rdata_valid,
   output logic [csr_pkg::grlen-1:0]     rdata_out,
   output logic                          redirect_valid,
   output logic [csr_pkg::grlen-1:0]     redirect_pc,
   output csr_pkg::trap_cause_e          redirect_cause,
   output logic                          bsec_ef
);

   logic                      illinst_csr;
   logic                      write_kill;
   logic                      exception;
   logic                      ertn;
   logic [csr_pkg::grlen-1:0] eentry;
   logic [csr_pkg::grlen-1:0] era;

   // decoder to register file
   csr_cmd_if csr_cmd ();

   csr_decode i_csr_decode (
      .clk         (clk),
      .reset       (reset),
      .op_valid    (op_valid),
      .op          (op),
      .csr_num     (csr_num),
      .rd_value    (rd_value),
      .rj_value    (rj_value),
      .write_kill  (write_kill),
      .illinst_csr (illinst_csr),
      .cmd         (csr_cmd.decoder),
      .rdata_valid (rdata_valid),
      .rdata_out   (rdata_out)
   );

   csr_regfile i_csr_regfile (
      .clk       (clk),
      .reset     (reset),
      .cmd       (csr_cmd.regfile),
      .exception (exception),
      .ertn      (ertn),
      .pc        (pc),
      .eentry    (eentry),
      .era       (era),
      .bsec_ef   (bsec_ef)
   );

   csr_trap_ctl i_csr_trap_ctl (
      .clk            (clk),
      .reset          (reset),
      .op_valid       (op_valid),
      .op             (op),
      .ale            (ale),
      .illinst        (illinst),
      .illinst_csr    (illinst_csr),
      .eentry         (eentry),
      .era            (era),
      .exception      (exception),
      .ertn           (ertn),
      .write_kill     (write_kill),
      .redirect_valid (redirect_valid),
      .redirect_pc    (redirect_pc),
      .redirect_cause (redirect_cause)
   );

endmodule
